// File: source/vlsu_pkg.sv
/*
  Shared types for the vector load/store unit.
  Elements are fixed at 32 bits. vl is limited to 255 elements.
  Memory word and byte enable widths depend on NrLanes, so each module
  derives them itself.
*/

`default_nettype none

package vlsu_pkg;

  // One vector element
  typedef logic [31:0] elen_t;

  localparam int unsigned ElenBytes = $bits(elen_t) / 8;

  // Vector length in elements
  typedef logic [7:0] vl_t;

  // Address generator states
  typedef enum logic [1:0] {
    ag_idle,
    ag_beats,
    ag_except
  } addrgen_state_e;

endpackage

`default_nettype wire

// File: source/vlsu_beat_if.sv
/*
  One beat request from the address generator to a load or store unit.
  addr, elem_en and last hold stable while valid is high and ready is low.
*/

`timescale 1ns/1ps
`default_nettype none

interface vlsu_beat_if #(
  parameter int unsigned NrLanes   = 2,
  parameter int unsigned AddrWidth = 32
) ();

  logic                 valid;
  logic [AddrWidth-1:0] addr;
  // One bit per lane, set for lanes below vl
  logic [NrLanes-1:0]   elem_en;
  logic                 last;
  logic                 ready;

  modport src (output valid, addr, elem_en, last, input ready);
  modport dst (input valid, addr, elem_en, last, output ready);

endinterface

`default_nettype wire

// File: source/vlsu_mem_if.sv
/*
  Memory requests of one unit toward the port arbiter.
  A request holds stable until gnt. Read data returns in order with one
  rvalid per granted read, at any latency.
*/

`timescale 1ns/1ps
`default_nettype none

interface vlsu_mem_if #(
  parameter int unsigned NrLanes   = 2,
  parameter int unsigned AddrWidth = 32
) ();

  import vlsu_pkg::*;

  localparam int unsigned DataWidth = NrLanes * $bits(elen_t);
  localparam int unsigned BeWidth   = NrLanes * ElenBytes;

  logic                 req;
  logic                 we;
  logic [AddrWidth-1:0] addr;
  logic [DataWidth-1:0] wdata;
  logic [BeWidth-1:0]   be;
  logic                 gnt;
  logic                 rvalid;
  logic [DataWidth-1:0] rdata;

  modport master (output req, we, addr, wdata, be, input gnt, rvalid, rdata);
  modport slave  (input req, we, addr, wdata, be, output gnt, rvalid, rdata);

endinterface

`default_nettype wire

// File: source/addrgen.sv
/*
  Address generator for unit-stride loads and stores.
  NrLanes must be a power of two so a beat is a power-of-two byte count.
  A base not aligned to a beat raises exception_o for one cycle and
  issues no beat. vl must be nonzero.
*/

`timescale 1ns/1ps
`default_nettype none

module addrgen #(
  parameter int unsigned NrLanes   = 2,
  parameter int unsigned AddrWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 pe_req_valid_i,
  input  logic                 pe_req_store_i,
  input  logic [AddrWidth-1:0] pe_req_base_i,
  input  vlsu_pkg::vl_t        pe_req_vl_i,
  input  logic                 busy_i,
  output logic                 pe_req_ready_o,
  output logic                 exception_o,
  vlsu_beat_if.src             ld_beat,
  vlsu_beat_if.src             st_beat
);

  import vlsu_pkg::*;

  localparam int unsigned BeatBytes = NrLanes * ElenBytes;
  localparam int unsigned BeatOffs  = $clog2(BeatBytes);

  addrgen_state_e       state_q;
  logic                 store_q;
  logic [AddrWidth-1:0] addr_q;
  vl_t                  left_q;
  logic [NrLanes-1:0]   elem_en;
  logic                 last;
  logic                 accept;
  logic                 misaligned;
  logic                 beat_ready;

  // Take a new instruction only once both units have drained
  assign pe_req_ready_o = (state_q == ag_idle) && !busy_i;
  assign accept         = pe_req_valid_i && pe_req_ready_o;
  assign misaligned     = |pe_req_base_i[BeatOffs-1:0];
  assign exception_o    = (state_q == ag_except);

  // Lanes holding elements below vl
  always_comb begin
    for (int unsigned i = 0; i < NrLanes; i++) begin
      elem_en[i] = (left_q > i);
    end
  end

  assign last = (left_q <= NrLanes);

  ////////////////////////////////////////
  // Beat outputs
  ////////////////////////////////////////

  assign ld_beat.valid   = (state_q == ag_beats) && !store_q;
  assign ld_beat.addr    = addr_q;
  assign ld_beat.elem_en = elem_en;
  assign ld_beat.last    = last;

  assign st_beat.valid   = (state_q == ag_beats) && store_q;
  assign st_beat.addr    = addr_q;
  assign st_beat.elem_en = elem_en;
  assign st_beat.last    = last;

  assign beat_ready = store_q ? st_beat.ready : ld_beat.ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ag_idle;
    end else begin
      unique case (state_q)
        ag_idle: begin
          if (accept) begin
            state_q <= misaligned ? ag_except : ag_beats;
          end
        end
        ag_beats: begin
          if (beat_ready && last) begin
            state_q <= ag_idle;
          end
        end
        default: state_q <= ag_idle;
      endcase
    end
  end

  // Instruction latch, then advance one beat per transfer
  always_ff @(posedge clk_i) begin
    if (accept) begin
      store_q <= pe_req_store_i;
      addr_q  <= pe_req_base_i;
      left_q  <= pe_req_vl_i;
    end else if ((state_q == ag_beats) && beat_ready) begin
      addr_q <= addr_q + AddrWidth'(BeatBytes);
      left_q <= left_q - vl_t'(NrLanes);
    end
  end

  a_vl_nonzero: assert property (@(posedge clk_i) disable iff (reset_i)
    accept |-> (pe_req_vl_i != '0))
    else $error("addrgen: instruction accepted with vl of zero");

endmodule

`default_nettype wire

// File: source/vldu.sv
/*
  Vector load unit.
  At most two beats are in flight, counted from read grant until every
  enabled lane has taken its element. Read data must return in order.
*/

`timescale 1ns/1ps
`default_nettype none

module vldu #(
  parameter int unsigned NrLanes   = 2,
  parameter int unsigned AddrWidth = 32
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  vlsu_beat_if.dst                      beat,
  vlsu_mem_if.master                    mem,
  output logic            [NrLanes-1:0] ldu_result_req_o,
  output vlsu_pkg::elen_t [NrLanes-1:0] ldu_result_wdata_o,
  input  logic            [NrLanes-1:0] ldu_result_gnt_i,
  output logic                          busy_o,
  output logic                          load_complete_o
);

  import vlsu_pkg::*;

  // Two beat slots, filled on read grant and freed when all lanes are done
  logic  [NrLanes-1:0]               en_q     [2];
  logic                              last_q   [2];
  logic                              dvalid_q [2];
  elen_t [NrLanes-1:0]               data_q   [2];
  logic                              wr_ptr_q;
  logic                              rd_ptr_q;
  logic                              dat_ptr_q;
  logic  [1:0]                       count_q;
  logic                              push;
  logic                              pop;
  logic  [NrLanes-1:0]               en_left;
  logic                              load_complete_q;

  ////////////////////////////////////////
  // Read issue
  ////////////////////////////////////////

  assign mem.req   = beat.valid && (count_q != 2'd2);
  assign mem.we    = 1'b0;
  assign mem.addr  = beat.addr;
  assign mem.wdata = '0;
  assign mem.be    = '1;

  assign push       = mem.req && mem.gnt;
  assign beat.ready = push;

  ////////////////////////////////////////
  // Lane results from the head slot
  ////////////////////////////////////////

  assign ldu_result_req_o   = dvalid_q[rd_ptr_q] ? en_q[rd_ptr_q] : '0;
  assign ldu_result_wdata_o = data_q[rd_ptr_q];

  // Lanes still waiting after this cycle's grants
  assign en_left = en_q[rd_ptr_q] & ~(ldu_result_gnt_i & ldu_result_req_o);
  assign pop     = dvalid_q[rd_ptr_q] && (en_left == '0);

  assign busy_o          = (count_q != 2'd0);
  assign load_complete_o = load_complete_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q        <= 1'b0;
      rd_ptr_q        <= 1'b0;
      dat_ptr_q       <= 1'b0;
      count_q         <= 2'd0;
      dvalid_q        <= '{default: 1'b0};
      load_complete_q <= 1'b0;
    end else begin
      load_complete_q <= pop && last_q[rd_ptr_q];
      count_q         <= count_q + 2'(push) - 2'(pop);
      if (push) begin
        wr_ptr_q           <= ~wr_ptr_q;
        dvalid_q[wr_ptr_q] <= 1'b0;
      end
      if (pop) begin
        rd_ptr_q           <= ~rd_ptr_q;
        dvalid_q[rd_ptr_q] <= 1'b0;
      end
      // Data lands in the oldest slot still waiting for it
      if (mem.rvalid) begin
        dat_ptr_q           <= ~dat_ptr_q;
        dvalid_q[dat_ptr_q] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (dvalid_q[rd_ptr_q]) begin
      en_q[rd_ptr_q] <= en_left;
    end
    if (push) begin
      en_q[wr_ptr_q]   <= beat.elem_en;
      last_q[wr_ptr_q] <= beat.last;
    end
    if (mem.rvalid) begin
      data_q[dat_ptr_q] <= mem.rdata;
    end
  end

  a_rvalid_slot: assert property (@(posedge clk_i) disable iff (reset_i)
    mem.rvalid |-> (count_q != 2'd0) && !dvalid_q[dat_ptr_q])
    else $error("vldu: read data with no slot waiting for it");

endmodule

`default_nettype wire

// File: source/vstu.sv
/*
  Vector store unit.
  Lanes must hold operand valid and data until operand ready, so the
  write request stays stable until granted. One write per beat.
*/

`timescale 1ns/1ps
`default_nettype none

module vstu #(
  parameter int unsigned NrLanes   = 2,
  parameter int unsigned AddrWidth = 32
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  vlsu_beat_if.dst                      beat,
  vlsu_mem_if.master                    mem,
  input  vlsu_pkg::elen_t [NrLanes-1:0] stu_operand_i,
  input  logic            [NrLanes-1:0] stu_operand_valid_i,
  output logic            [NrLanes-1:0] stu_operand_ready_o,
  output logic                          busy_o,
  output logic                          store_pending_o,
  output logic                          store_complete_o
);

  import vlsu_pkg::*;

  logic                         operands_ok;
  logic [NrLanes*ElenBytes-1:0] be;
  logic                         store_complete_q;

  // Every enabled lane has its operand
  assign operands_ok = &(stu_operand_valid_i | ~beat.elem_en);

  always_comb begin
    for (int unsigned i = 0; i < NrLanes; i++) begin
      be[i*ElenBytes +: ElenBytes] = {ElenBytes{beat.elem_en[i]}};
    end
  end

  ////////////////////////////////////////
  // Write issue
  ////////////////////////////////////////

  assign mem.req   = beat.valid && operands_ok;
  assign mem.we    = 1'b1;
  assign mem.addr  = beat.addr;
  assign mem.wdata = stu_operand_i;
  assign mem.be    = be;

  // A granted write consumes the beat and the operands behind it
  assign beat.ready          = mem.gnt;
  assign stu_operand_ready_o = {NrLanes{mem.gnt}} & beat.elem_en;

  assign busy_o           = beat.valid;
  assign store_pending_o  = beat.valid;
  assign store_complete_o = store_complete_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      store_complete_q <= 1'b0;
    end else begin
      store_complete_q <= mem.gnt && beat.last;
    end
  end

  // Waiting write stays a stable write
  a_write_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    mem.req && !mem.gnt |=> mem.req && mem.we && $stable(mem.addr) && $stable(mem.be))
    else $error("vstu: write request changed before grant");

endmodule

`default_nettype wire

// File: source/vlsu_mem_arb.sv
/*
  Round-robin merge of the load and store units onto one memory port.
  The winner stays selected until granted. Read responses must come
  back in order, and only the load side reads.
*/

`timescale 1ns/1ps
`default_nettype none

module vlsu_mem_arb #(
  parameter int unsigned NrLanes   = 2,
  parameter int unsigned AddrWidth = 32
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  vlsu_mem_if.slave                              ld,
  vlsu_mem_if.slave                              st,
  output logic                                   mem_req_o,
  output logic                                   mem_we_o,
  output logic [AddrWidth-1:0]                   mem_addr_o,
  output logic [NrLanes*vlsu_pkg::ElenBytes*8-1:0] mem_wdata_o,
  output logic [NrLanes*vlsu_pkg::ElenBytes-1:0] mem_be_o,
  input  logic                                   mem_gnt_i,
  input  logic                                   mem_rvalid_i,
  input  logic [NrLanes*vlsu_pkg::ElenBytes*8-1:0] mem_rdata_i
);

  logic       sel;
  logic       sel_q;
  logic       locked_q;
  logic       last_st_q;
  logic [2:0] rd_out_q;
  logic       rd_gnt;

  // High selects the store unit
  always_comb begin
    if (locked_q) begin
      sel = sel_q;
    end else if (ld.req && st.req) begin
      sel = !last_st_q;
    end else begin
      sel = st.req;
    end
  end

  assign mem_req_o   = sel ? st.req   : ld.req;
  assign mem_we_o    = sel ? st.we    : ld.we;
  assign mem_addr_o  = sel ? st.addr  : ld.addr;
  assign mem_wdata_o = sel ? st.wdata : ld.wdata;
  assign mem_be_o    = sel ? st.be    : ld.be;

  assign ld.gnt = mem_gnt_i && !sel;
  assign st.gnt = mem_gnt_i && sel;

  // Responses go to the load side only
  assign ld.rvalid = mem_rvalid_i && (rd_out_q != 3'd0);
  assign ld.rdata  = mem_rdata_i;
  assign st.rvalid = 1'b0;
  assign st.rdata  = '0;

  assign rd_gnt = mem_req_o && mem_gnt_i && !mem_we_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      locked_q  <= 1'b0;
      last_st_q <= 1'b0;
      rd_out_q  <= 3'd0;
    end else begin
      locked_q <= mem_req_o && !mem_gnt_i;
      rd_out_q <= rd_out_q + 3'(rd_gnt) - 3'(ld.rvalid);
      if (mem_req_o && mem_gnt_i) begin
        last_st_q <= sel;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    sel_q <= sel;
  end

  ////////////////////////////////////////
  // Port checks
  ////////////////////////////////////////

  a_rvalid_owed: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_rvalid_i |-> (rd_out_q != 3'd0))
    else $error("vlsu_mem_arb: read response with no read outstanding");

  a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o)
      && $stable(mem_wdata_o) && $stable(mem_be_o))
    else $error("vlsu_mem_arb: memory request changed before grant");

endmodule

`default_nettype wire

// File: source/vlsu.sv
/*
  Vector load/store unit top level.
  Unit-stride loads and stores only, one instruction at a time.
  Memory port is request/grant with in-order read responses.
*/

`timescale 1ns/1ps
`default_nettype none

module vlsu #(
  parameter int unsigned NrLanes   = 2,
  parameter int unsigned AddrWidth = 32
) (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  // Sequencer
  input  logic                                     pe_req_valid_i,
  input  logic                                     pe_req_store_i,
  input  logic            [AddrWidth-1:0]          pe_req_base_i,
  input  vlsu_pkg::vl_t                            pe_req_vl_i,
  output logic                                     pe_req_ready_o,
  // Lane operands for stores
  input  vlsu_pkg::elen_t [NrLanes-1:0]            stu_operand_i,
  input  logic            [NrLanes-1:0]            stu_operand_valid_i,
  output logic            [NrLanes-1:0]            stu_operand_ready_o,
  // Lane results for loads
  output logic            [NrLanes-1:0]            ldu_result_req_o,
  output vlsu_pkg::elen_t [NrLanes-1:0]            ldu_result_wdata_o,
  input  logic            [NrLanes-1:0]            ldu_result_gnt_i,
  // Memory port
  output logic                                     mem_req_o,
  output logic                                     mem_we_o,
  output logic            [AddrWidth-1:0]          mem_addr_o,
  output logic [NrLanes*vlsu_pkg::ElenBytes*8-1:0] mem_wdata_o,
  output logic [NrLanes*vlsu_pkg::ElenBytes-1:0]   mem_be_o,
  input  logic                                     mem_gnt_i,
  input  logic                                     mem_rvalid_i,
  input  logic [NrLanes*vlsu_pkg::ElenBytes*8-1:0] mem_rdata_i,
  // Dispatcher
  output logic                                     load_complete_o,
  output logic                                     store_complete_o,
  output logic                                     store_pending_o,
  output logic                                     addrgen_exception_o
);

  logic ldu_busy;
  logic stu_busy;

  vlsu_beat_if #(.NrLanes(NrLanes), .AddrWidth(AddrWidth)) ld_beat ();
  vlsu_beat_if #(.NrLanes(NrLanes), .AddrWidth(AddrWidth)) st_beat ();
  vlsu_mem_if  #(.NrLanes(NrLanes), .AddrWidth(AddrWidth)) ld_mem ();
  vlsu_mem_if  #(.NrLanes(NrLanes), .AddrWidth(AddrWidth)) st_mem ();

  addrgen #(.NrLanes(NrLanes), .AddrWidth(AddrWidth)) i_addrgen (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .pe_req_valid_i (pe_req_valid_i),
    .pe_req_store_i (pe_req_store_i),
    .pe_req_base_i  (pe_req_base_i),
    .pe_req_vl_i    (pe_req_vl_i),
    .busy_i         (ldu_busy | stu_busy),
    .pe_req_ready_o (pe_req_ready_o),
    .exception_o    (addrgen_exception_o),
    .ld_beat        (ld_beat),
    .st_beat        (st_beat)
  );

  vldu #(.NrLanes(NrLanes), .AddrWidth(AddrWidth)) i_vldu (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .beat               (ld_beat),
    .mem                (ld_mem),
    .ldu_result_req_o   (ldu_result_req_o),
    .ldu_result_wdata_o (ldu_result_wdata_o),
    .ldu_result_gnt_i   (ldu_result_gnt_i),
    .busy_o             (ldu_busy),
    .load_complete_o    (load_complete_o)
  );

  vstu #(.NrLanes(NrLanes), .AddrWidth(AddrWidth)) i_vstu (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .beat                (st_beat),
    .mem                 (st_mem),
    .stu_operand_i       (stu_operand_i),
    .stu_operand_valid_i (stu_operand_valid_i),
    .stu_operand_ready_o (stu_operand_ready_o),
    .busy_o              (stu_busy),
    .store_pending_o     (store_pending_o),
    .store_complete_o    (store_complete_o)
  );

  vlsu_mem_arb #(.NrLanes(NrLanes), .AddrWidth(AddrWidth)) i_mem_arb (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .ld           (ld_mem),
    .st           (st_mem),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_be_o     (mem_be_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

  if (NrLanes == 0) begin : g_lane_check
    $error("vlsu: at least one lane is required");
  end

endmodule

`default_nettype wire

// File: test/tb_vlsu_mem.sv
/*
  Testbench memory model, 256 bytes, indexed by the low address byte.
  Grant is random each cycle, reads return one cycle after grant.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_vlsu_mem #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  logic [31:0]               addr_i,
  input  logic [NrLanes*32-1:0]     wdata_i,
  input  logic [NrLanes*4-1:0]      be_i,
  output logic                      gnt_o,
  output logic                      rvalid_o,
  output logic [NrLanes*32-1:0]     rdata_o
);

  logic [7:0]  bytes [256];
  logic [31:0] rng;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Fill pattern over the whole byte address
  initial begin
    for (int a = 0; a < 256; a++) begin
      bytes[a] = 8'(a * 37 + 11);
    end
    rng      = 32'd34499;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
  end

  always @(posedge clk_i) begin
    logic [7:0] base;
    base = addr_i[7:0];
    rng = xorshift(rng);
    if (reset_i) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      // Stall roughly one cycle in four
      gnt_o    <= (rng[1:0] != 2'b00);
      rvalid_o <= req_i && gnt_o && !we_i;
      if (req_i && gnt_o) begin
        for (int b = 0; b < NrLanes * 4; b++) begin
          if (we_i && be_i[b]) begin
            bytes[8'(base + b)] = wdata_i[b*8 +: 8];
          end
          rdata_o[b*8 +: 8] <= bytes[8'(base + b)];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: test/tb_vlsu.sv
/*
  Testbench for the vector load/store unit with NrLanes of 2.
  Stores then loads through a 256-byte memory model, so bases stay small.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_vlsu;

  localparam int NrLanes = 2;

  logic clk = 1'b0;
  logic reset_i;
  logic pe_req_valid_i, pe_req_store_i, pe_req_ready_o;
  logic [31:0] pe_req_base_i;
  logic [7:0] pe_req_vl_i;
  logic [NrLanes-1:0][31:0] stu_operand_i, ldu_result_wdata_o;
  logic [NrLanes-1:0] stu_operand_valid_i, stu_operand_ready_o;
  logic [NrLanes-1:0] ldu_result_req_o, ldu_result_gnt_i;
  logic mem_req_o, mem_we_o, mem_gnt_i, mem_rvalid_i;
  logic [31:0] mem_addr_o;
  logic [NrLanes*32-1:0] mem_wdata_o, mem_rdata_i;
  logic [NrLanes*4-1:0] mem_be_o;
  logic load_complete_o, store_complete_o, store_pending_o, addrgen_exception_o;

  logic [31:0] store_data [256];
  logic [31:0] rng, seq_rng;
  logic        cur_store;
  logic [31:0] cur_base;
  int          cur_vl, pending, done_cnt;
  int          ld_cnt [NrLanes];
  int          st_cnt [NrLanes];
  logic        no_req;
  string       cur_test;
  logic        accept;

  always #2 clk = ~clk;

  vlsu #(.NrLanes(NrLanes), .AddrWidth(32)) dut (.*, .clk_i(clk));

  tb_vlsu_mem #(.NrLanes(NrLanes)) i_mem (
    .clk_i(clk), .reset_i(reset_i), .req_i(mem_req_o), .we_i(mem_we_o),
    .addr_i(mem_addr_o), .wdata_i(mem_wdata_o), .be_i(mem_be_o),
    .gnt_o(mem_gnt_i), .rvalid_o(mem_rvalid_i), .rdata_o(mem_rdata_i)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] model_elem(input logic [31:0] addr);
    return {i_mem.bytes[8'(addr + 3)], i_mem.bytes[8'(addr + 2)],
            i_mem.bytes[8'(addr + 1)], i_mem.bytes[addr[7:0]]};
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic show_mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
    stop_with_error($sformatf("MISMATCH %s expected %0h actual %0h", name, exp, act));
  endtask

  //////////////////////////////////////////
  // Protocol checks on every cycle
  //////////////////////////////////////////

  a_mem_hold: assert property (@(posedge clk) disable iff (reset_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_we_o)
      && $stable(mem_wdata_o) && $stable(mem_be_o))
    else stop_with_error("memory request changed before grant");

  for (genvar l = 0; l < NrLanes; l++) begin : g_lane_hold
    a_result_hold: assert property (@(posedge clk) disable iff (reset_i)
      ldu_result_req_o[l] && !ldu_result_gnt_i[l]
        |=> ldu_result_req_o[l] && $stable(ldu_result_wdata_o[l]))
      else stop_with_error("lane result dropped or changed before grant");
  end

  assign accept = pe_req_valid_i && pe_req_ready_o;

  // Completion accounting and the quiet window after a misaligned base
  always @(posedge clk) begin
    logic done;
    done = load_complete_o || store_complete_o || addrgen_exception_o;
    if (reset_i) begin
      pending  <= 0;
      done_cnt <= 0;
      no_req   <= 1'b0;
    end else begin
      assert (!(pe_req_ready_o && pending != 0 && !done))
        else stop_with_error("sequencer ready while an instruction is open");
      assert (!(done && pending == 0))
        else stop_with_error("completion pulse with no open instruction");
      assert (!(load_complete_o && cur_store) && !(store_complete_o && !cur_store))
        else stop_with_error("completion pulse of the wrong kind");
      assert (!(store_pending_o && (pending == 0 || !cur_store)))
        else stop_with_error("store pending outside a store");
      assert (!(pending != 0 && cur_store && !done && !store_pending_o))
        else stop_with_error("store pending low during a store");
      assert (!(no_req && mem_req_o))
        else stop_with_error("memory request after a misaligned base");
      assert (!done || addrgen_exception_o == (cur_base % (NrLanes * 4) != 0))
        else stop_with_error("exception pulse does not match base alignment");
      pending  <= pending - int'(done) + int'(accept);
      done_cnt <= done_cnt + int'(done);
      if (accept) begin
        no_req <= (pe_req_base_i % (NrLanes * 4) != 0);
      end
    end
  end

  // Lane sinks with random grants and lane operand sources
  always @(posedge clk) begin
    int idx;
    rng = xorshift(rng);
    if (reset_i) begin
      ldu_result_gnt_i    <= '0;
      stu_operand_valid_i <= '0;
      for (int i = 0; i < NrLanes; i++) begin
        ld_cnt[i] = 0;
        st_cnt[i] = 0;
      end
    end else if (accept) begin
      for (int i = 0; i < NrLanes; i++) begin
        ld_cnt[i] = 0;
        st_cnt[i] = 0;
      end
    end else begin
      for (int i = 0; i < NrLanes; i++) begin
        if (ldu_result_req_o[i] && ldu_result_gnt_i[i]) begin
          idx = ld_cnt[i] * NrLanes + i;
          assert (idx < cur_vl)
            else stop_with_error("lane result request past vl");
          assert (ldu_result_wdata_o[i] == model_elem(cur_base + 32'(idx * 4)))
            else show_mismatch(cur_test, model_elem(cur_base + 32'(idx * 4)),
                               ldu_result_wdata_o[i]);
          ld_cnt[i] = ld_cnt[i] + 1;
        end
        idx = st_cnt[i] * NrLanes + i;
        if (stu_operand_valid_i[i] && stu_operand_ready_o[i]) begin
          stu_operand_valid_i[i] <= 1'b0;
          st_cnt[i] = st_cnt[i] + 1;
        end else if (!stu_operand_valid_i[i] && cur_store && pending != 0
                     && idx < cur_vl && rng[i + 4]) begin
          stu_operand_valid_i[i] <= 1'b1;
          stu_operand_i[i]       <= store_data[idx];
        end
        ldu_result_gnt_i[i] <= rng[i + 8] | rng[i + 12];
      end
    end
  end

  task automatic run_instr(input logic store, input logic [31:0] base, input int vl);
    int n;
    int start;
    n = 0;
    while (!pe_req_ready_o) begin
      @(posedge clk);
      n++;
      if (n > 1000) stop_with_error("timeout waiting for sequencer ready");
    end
    cur_store = store;
    cur_base  = base;
    cur_vl    = vl;
    start     = done_cnt;
    pe_req_valid_i <= 1'b1;
    pe_req_store_i <= store;
    pe_req_base_i  <= base;
    pe_req_vl_i    <= 8'(vl);
    @(posedge clk);
    pe_req_valid_i <= 1'b0;
    n = 0;
    while (done_cnt == start) begin
      @(posedge clk);
      n++;
      if (n > 2000) stop_with_error("timeout waiting for completion or exception");
    end
  endtask

  task automatic check_lane_counts(input int vl);
    int exp;
    for (int i = 0; i < NrLanes; i++) begin
      exp = (vl > i) ? (vl - i - 1) / NrLanes + 1 : 0;
      assert (ld_cnt[i] == exp) else show_mismatch(cur_test, exp, ld_cnt[i]);
    end
  endtask

  task automatic store_and_check(input logic [31:0] base, input int vl);
    for (int k = 0; k < vl; k++) begin
      seq_rng = xorshift(seq_rng);
      store_data[k] = seq_rng;
    end
    run_instr(1'b1, base, vl);
    for (int k = 0; k < vl; k++) begin
      assert (model_elem(base + 32'(k * 4)) == store_data[k])
        else show_mismatch(cur_test, store_data[k], model_elem(base + 32'(k * 4)));
    end
  endtask

  initial begin
    logic [7:0] snap [32];
    int vl;
    rng = 32'd34499;
    seq_rng = xorshift(32'd34499);
    reset_i = 1'b1;
    pe_req_valid_i = 1'b0;
    pe_req_store_i = 1'b0;
    pe_req_base_i = '0;
    pe_req_vl_i = '0;
    stu_operand_i = '0;
    stu_operand_valid_i = '0;
    ldu_result_gnt_i = '0;
    cur_store = 1'b0;
    cur_base = '0;
    cur_vl = 0;
    repeat (2) @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);

    cur_test = "reset";
    assert (pe_req_ready_o && !mem_req_o && ldu_result_req_o == '0 && !load_complete_o
            && !store_complete_o && !store_pending_o && !addrgen_exception_o)
      else stop_with_error("outputs not idle right after reset");
    @(posedge clk);

    // Round trip at an aligned base
    cur_test = "round_trip";
    seq_rng = xorshift(seq_rng);
    vl = 1 + int'(seq_rng % 32);
    store_and_check(32'h40, vl);
    run_instr(1'b0, 32'h40, vl);
    check_lane_counts(vl);

    // Odd vl leaves the upper lane of the last beat alone
    cur_test = "partial_beat";
    for (int k = 0; k < 32; k++) snap[k] = i_mem.bytes[8'h80 + k];
    store_and_check(32'h80, 5);
    for (int k = 20; k < 32; k++) begin
      assert (i_mem.bytes[8'h80 + k] == snap[k])
        else show_mismatch(cur_test, snap[k], i_mem.bytes[8'h80 + k]);
    end
    run_instr(1'b0, 32'h80, 5);
    check_lane_counts(5);

    cur_test = "misaligned";
    run_instr(1'b0, 32'h44, 4);
    repeat (5) @(posedge clk);
    cur_test = "after_exception";
    store_and_check(32'h00, 3);
    run_instr(1'b0, 32'h00, 3);
    check_lane_counts(3);

    repeat (3) @(posedge clk);
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlsu_lite.f
source/vlsu_pkg.sv
source/vlsu_beat_if.sv
source/vlsu_mem_if.sv
source/addrgen.sv
source/vldu.sv
source/vstu.sv
source/vlsu_mem_arb.sv
source/vlsu.sv
test/tb_vlsu_mem.sv
test/tb_vlsu.sv

// File: Makefile
# Verilator build and run for the vector load/store unit testbench

TOP = tb_vlsu

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f vlsu_lite.f --top-module $(TOP) \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "\*\* PASS \*\*" sim.log

lint:
	verilator --lint-only --timing -f vlsu_lite.f --top-module $(TOP)
	verilator --lint-only -f vlsu_lite.f --top-module vlsu

clean:
	rm -rf obj_dir sim.log
